// File: project.f
+incdir+hdl
hdl/posit_types_pkg.sv
hdl/accum_regs_pkg.sv
hdl/accum_result_if.sv
hdl/posit_decoder.sv
hdl/raw_accumulator.sv
hdl/accum_axil_regs.sv
hdl/posit_accum_top.sv
tests/tb_posit_accum.sv

// File: tests/tb_posit_accum.sv
/* Self-checking testbench for the posit accumulator with a fixed-seed random stream.
   Expected sums come from an integer model of the es3 decode and truncating accumulate */
module tb_posit_accum;

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [3:0] ADDR_CTRL   = 4'h0;
    localparam logic [3:0] ADDR_STATUS = 4'h4;
    localparam logic [3:0] ADDR_FRAC   = 4'h8;
    localparam logic [3:0] ADDR_EXP    = 4'hC;

    localparam int N_DEC       = 16;
    localparam int N_ACC       = 200;
    localparam int N_CANCEL    = 4;
    localparam int N_INF_AFTER = 3;
    localparam int N_BP        = 8;
    localparam int HANG_LIMIT  = 200;

    // Budget of 40 cycles per posit and 20 per AXI access, plus reset
    localparam int POSITS = N_DEC + N_ACC + 2 * N_CANCEL + N_CANCEL / 2 + 2 + N_INF_AFTER +
                            N_BP;
    localparam int AXI_OPS = 3 + 4 * N_DEC + (1 + 3 * N_ACC) + 6 * N_CANCEL +
                             (1 + 3 * (2 + N_INF_AFTER) + (1 + N_INF_AFTER) + 2) + 4;
    localparam int CYCLE_LIMIT = 40 * POSITS + 20 * AXI_OPS + 10;

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic        in_ready;
    logic [15:0] in_posit;
    logic [3:0]  s_awaddr;
    logic        s_awvalid;
    logic        s_awready;
    logic [31:0] s_wdata;
    logic [3:0]  s_wstrb;
    logic        s_wvalid;
    logic        s_wready;
    logic [1:0]  s_bresp;
    logic        s_bvalid;
    logic        s_bready;
    logic [3:0]  s_araddr;
    logic        s_arvalid;
    logic        s_arready;
    logic [31:0] s_rdata;
    logic [1:0]  s_rresp;
    logic        s_rvalid;
    logic        s_rready;

    logic [31:0] rng = 32'hc1ed;
    int          cycle = 0;
    int          fail_count = 0;

    // Model of the accumulator state
    bit m_sgn;
    int m_scale;
    int m_frac;
    bit m_zero;
    bit m_inf;
    bit m_trunc;
    int m_count;

    posit_accum_top uut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_posit  (in_posit),
        .s_awaddr  (s_awaddr),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .s_wdata   (s_wdata),
        .s_wstrb   (s_wstrb),
        .s_wvalid  (s_wvalid),
        .s_wready  (s_wready),
        .s_bresp   (s_bresp),
        .s_bvalid  (s_bvalid),
        .s_bready  (s_bready),
        .s_araddr  (s_araddr),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .s_rdata   (s_rdata),
        .s_rresp   (s_rresp),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle = cycle + 1;
        if (cycle > CYCLE_LIMIT)
        begin
            $display("Timeout: the run went past %0d clock cycles", CYCLE_LIMIT);
            $display("Checks failed");
            $fatal(1);
        end
    end

    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            fail_count = fail_count + 1;
            $display("FAILED at %0d ns: %s, got %h, expected %h", $time, what, actual,
                     expected);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic hang_check(inout int n, input string what);
        n = n + 1;
        if (n > HANG_LIMIT)
        begin
            $display("Handshake hang: no %s after %0d cycles", what, HANG_LIMIT);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic to_drive_point();
        @(posedge clk);
        #5;
    endtask

    // es3 decode walks the regime run, terminator, 3 exponent bits, then fraction
    function automatic void decode_posit(input logic [15:0] w, output bit sgn,
                                         output int scale, output int frac,
                                         output bit inf, output bit zero);
        logic [15:0] mag;
        int          i;
        int          run;
        int          k;
        int          nbits;
        int          tail;
        int          fb;
        sgn   = 1'b0;
        scale = 0;
        frac  = 0;
        inf   = (w == 16'h8000);
        zero  = (w == 16'h0000);
        if (!inf && !zero)
        begin
            sgn = w[15];
            mag = w[15] ? (~w + 16'd1) : w;
            run = 0;
            i = 14;
            while (i >= 0 && mag[i] == mag[14])
            begin
                run = run + 1;
                i = i - 1;
            end
            k = mag[14] ? run - 1 : -run;
            nbits = (i > 0) ? i : 0;
            tail = int'(mag) & ((1 << nbits) - 1);
            if (nbits >= 3)
            begin
                fb = nbits - 3;
                scale = 8 * k + (tail >> fb);
                frac = (tail & ((1 << fb) - 1)) << (24 - fb);
            end
            else
                scale = 8 * k + (tail << (3 - nbits));
        end
    endfunction

    function automatic void model_clear();
        m_sgn   = 1'b0;
        m_scale = 0;
        m_frac  = 0;
        m_zero  = 1'b1;
        m_inf   = 1'b0;
        m_trunc = 1'b0;
        m_count = 0;
    endfunction

    function automatic void model_add(input logic [15:0] w);
        bit     o_sgn;
        bit     o_inf;
        bit     o_zero;
        int     o_scale;
        int     o_frac;
        bit     new_hi;
        bit     h_sgn;
        bit     l_sgn;
        int     h_scale;
        int     diff;
        longint h_mag;
        longint l_mag;
        longint sum;
        bit     lost;
        int     scale;
        decode_posit(w, o_sgn, o_scale, o_frac, o_inf, o_zero);
        m_count = m_count + 1;
        // Larger magnitude is hi and a tie goes to the new operand
        if (m_zero)
            new_hi = 1'b1;
        else if (o_zero)
            new_hi = 1'b0;
        else
            new_hi = (o_scale > m_scale) || (o_scale == m_scale && o_frac >= m_frac);
        h_sgn   = new_hi ? o_sgn : m_sgn;
        l_sgn   = new_hi ? m_sgn : o_sgn;
        h_scale = new_hi ? o_scale : m_scale;
        h_mag = new_hi ? (o_zero ? 0 : (64'd1 << 24) + o_frac)
                       : (m_zero ? 0 : (64'd1 << 24) + m_frac);
        l_mag = new_hi ? (m_zero ? 0 : (64'd1 << 24) + m_frac)
                       : (o_zero ? 0 : (64'd1 << 24) + o_frac);
        diff = (l_mag == 0) ? 0 : h_scale - (new_hi ? m_scale : o_scale);
        if (diff >= 25)
        begin
            lost = (l_mag != 0);
            l_mag = 0;
        end
        else
        begin
            lost = (l_mag & ((64'd1 << diff) - 1)) != 0;
            l_mag = l_mag >> diff;
        end
        sum = (h_sgn != l_sgn) ? h_mag - l_mag : h_mag + l_mag;
        scale = h_scale;
        if (sum >= (64'd1 << 25))
        begin
            lost = lost || sum[0];
            sum = sum >> 1;
            scale = scale + 1;
        end
        else if (sum != 0)
        begin
            while (sum < (64'd1 << 24))
            begin
                sum = sum << 1;
                scale = scale - 1;
            end
        end
        m_trunc = m_trunc || lost;
        m_sgn   = 1'b0;
        m_scale = 0;
        m_frac  = 0;
        m_zero  = 1'b0;
        if (o_inf || m_inf || (sum != 0 && (scale > 255 || scale < -255)))
            m_inf = 1'b1;
        else if (sum == 0)
            m_zero = 1'b1;
        else
        begin
            m_sgn   = h_sgn;
            m_scale = scale;
            m_frac  = int'(sum & 64'hFF_FFFF);
        end
    endfunction

    function automatic logic [15:0] random_posit(input int max_scale);
        logic [31:0] r;
        logic [15:0] w;
        bit          s;
        bit          inf;
        bit          zero;
        int          scale;
        int          frac;
        bit          found;
        found = 1'b0;
        w = 16'h4000;
        while (!found)
        begin
            r = next_random();
            w = r[15:0];
            decode_posit(w, s, scale, frac, inf, zero);
            found = !inf && !zero && scale <= max_scale && scale >= -max_scale;
        end
        return w;
    endfunction

    task automatic send_posit(input logic [15:0] word);
        int n;
        in_posit = word;
        in_valid = 1'b1;
        n = 0;
        @(negedge clk);
        while (!in_ready)
        begin
            hang_check(n, "in_ready for a new posit");
            @(negedge clk);
        end
        to_drive_point();
        in_valid = 1'b0;
        model_add(word);
        n = 0;
        @(negedge clk);
        while (!in_ready)
        begin
            hang_check(n, "end of the accumulate pass");
            @(negedge clk);
        end
        to_drive_point();
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data);
        int          n;
        int          stall;
        logic [31:0] held;
        s_araddr  = addr;
        s_arvalid = 1'b1;
        n = 0;
        @(negedge clk);
        while (!s_arready)
        begin
            hang_check(n, "arready");
            @(negedge clk);
        end
        to_drive_point();
        s_arvalid = 1'b0;
        n = 0;
        @(negedge clk);
        while (!s_rvalid)
        begin
            hang_check(n, "rvalid");
            @(negedge clk);
        end
        held = s_rdata;
        stall = int'(next_random() % 8);
        // Data must not move while rready is withheld
        repeat (stall)
        begin
            to_drive_point();
            @(negedge clk);
            check_equal({31'b0, s_rvalid}, 32'd1, "rvalid held while rready low");
            check_equal(s_rdata, held, "rdata stable while rready low");
        end
        to_drive_point();
        s_rready = 1'b1;
        @(negedge clk);
        check_equal({31'b0, s_rvalid}, 32'd1, "rvalid at rready");
        check_equal(s_rdata, held, "rdata at rready");
        check_equal({30'b0, s_rresp}, 32'd0, "rresp OKAY");
        data = held;
        to_drive_point();
        s_rready = 1'b0;
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
        int n;
        int stall;
        s_awaddr  = addr;
        s_wdata   = data;
        s_wstrb   = 4'hF;
        s_awvalid = 1'b1;
        s_wvalid  = 1'b1;
        n = 0;
        @(negedge clk);
        while (!(s_awready && s_wready))
        begin
            hang_check(n, "awready and wready");
            @(negedge clk);
        end
        to_drive_point();
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        n = 0;
        @(negedge clk);
        while (!s_bvalid)
        begin
            hang_check(n, "bvalid");
            @(negedge clk);
        end
        stall = int'(next_random() % 8);
        repeat (stall)
        begin
            to_drive_point();
            @(negedge clk);
            check_equal({31'b0, s_bvalid}, 32'd1, "bvalid held while bready low");
        end
        to_drive_point();
        s_bready = 1'b1;
        @(negedge clk);
        check_equal({30'b0, s_bresp}, 32'd0, "bresp OKAY");
        to_drive_point();
        s_bready = 1'b0;
    endtask

    task automatic clear_accum();
        axi_write(ADDR_CTRL, 32'd1);
        model_clear();
    endtask

    task automatic check_result(input string tag);
        logic [31:0] rd;
        logic [31:0] exp_status;
        logic [31:0] exp_exp;
        exp_status = ((m_count & 32'hFFFF) << 16) | (m_inf << 2) | (m_trunc << 1);
        exp_exp = (m_scale & 32'h1FF) | (m_sgn << 16) | (m_zero << 17);
        axi_read(ADDR_STATUS, rd);
        check_equal(rd, exp_status, {tag, " status"});
        axi_read(ADDR_FRAC, rd);
        check_equal(rd, m_frac, {tag, " fraction"});
        axi_read(ADDR_EXP, rd);
        check_equal(rd, exp_exp, {tag, " scale and sign"});
    endtask

    initial
    begin
        logic [15:0] fixed_words [6];
        logic [15:0] word;
        logic [31:0] r;
        logic [31:0] rd;
        int          n;
        int          last_accept;
        fixed_words = '{16'h0000, 16'h8000, 16'h4000, 16'hC000, 16'h7FFF, 16'h0001};
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_posit  = '0;
        s_awaddr  = '0;
        s_awvalid = 1'b0;
        s_wdata   = '0;
        s_wstrb   = '0;
        s_wvalid  = 1'b0;
        s_bready  = 1'b0;
        s_araddr  = '0;
        s_arvalid = 1'b0;
        s_rready  = 1'b0;
        repeat (5) @(posedge clk);
        #5;
        rst = 1'b0;

        // Idle state after reset
        check_equal({31'b0, in_ready}, 32'd1, "in_ready after reset");
        axi_read(ADDR_STATUS, rd);
        check_equal(rd, 32'd0, "status after reset");
        axi_read(ADDR_EXP, rd);
        check_equal(rd, 32'h0002_0000, "exp after reset");
        axi_read(ADDR_FRAC, rd);
        check_equal(rd, 32'd0, "fraction after reset");

        // Single words onto a cleared sum show the decode
        for (int i = 0; i < N_DEC; i++)
        begin
            if (i < 6)
                word = fixed_words[i];
            else
            begin
                r = next_random();
                word = r[15:0];
            end
            clear_accum();
            send_posit(word);
            check_result($sformatf("decode of %h", word));
        end

        clear_accum();
        for (int i = 0; i < N_ACC; i++)
        begin
            send_posit(random_posit(40));
            check_result($sformatf("accumulate step %0d", i));
        end

        for (int i = 0; i < N_CANCEL; i++)
        begin
            clear_accum();
            word = random_posit(40);
            send_posit(word);
            // minpos lies far below x, so it only sets truncated
            if (i % 2 == 1)
                send_posit(16'h0001);
            send_posit(~word + 16'd1);
            check_result("cancellation");
            axi_read(ADDR_EXP, rd);
            check_equal(rd, 32'h0002_0000, "cancellation gives zero with sgn 0");
            axi_read(ADDR_STATUS, rd);
            check_equal({31'b0, rd[1]}, i % 2, "truncated kept over cancellation");
        end

        // NaR latches inf until the next clear
        clear_accum();
        send_posit(random_posit(40));
        check_result("before NaR");
        send_posit(16'h8000);
        check_result("NaR input");
        axi_read(ADDR_STATUS, rd);
        check_equal({31'b0, rd[2]}, 32'd1, "inf set by NaR");
        for (int i = 0; i < N_INF_AFTER; i++)
        begin
            send_posit(random_posit(40));
            check_result("after NaR");
            axi_read(ADDR_STATUS, rd);
            check_equal({31'b0, rd[2]}, 32'd1, "inf still set");
        end
        clear_accum();
        axi_read(ADDR_STATUS, rd);
        check_equal({31'b0, rd[2]}, 32'd0, "inf cleared");

        // With in_valid held high only one word goes in per pass
        clear_accum();
        last_accept = -100;
        in_valid = 1'b1;
        for (int i = 0; i < N_BP; i++)
        begin
            word = random_posit(40);
            in_posit = word;
            n = 0;
            @(negedge clk);
            while (!in_ready)
            begin
                hang_check(n, "in_ready with in_valid held");
                @(negedge clk);
            end
            check_equal(cycle - last_accept >= 5, 32'd1, "accept spacing with valid held");
            last_accept = cycle;
            model_add(word);
            to_drive_point();
        end
        in_valid = 1'b0;
        n = 0;
        @(negedge clk);
        while (!in_ready)
        begin
            hang_check(n, "end of the held-valid run");
            @(negedge clk);
        end
        to_drive_point();
        check_result("held valid");

        if (fail_count == 0)
        begin
            $display("All checks passed");
            $finish;
        end
        else
        begin
            $display("Checks failed");
            $fatal(1);
        end
    end

endmodule

// File: hdl/posit_accum_top.sv
/* Posit stream accumulator with AXI4-Lite result access.
   in_ready stays low for the whole pass of an accepted posit */
`include "posit_accum_params.svh"

module posit_accum_top
    import posit_types_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  logic [`POSIT_WIDTH-1:0]     in_posit,
    input  logic [`AXI_ADDR_BITS-1:0]   s_awaddr,
    input  logic                        s_awvalid,
    output logic                        s_awready,
    input  logic [`AXI_DATA_BITS-1:0]   s_wdata,
    input  logic [`AXI_DATA_BITS/8-1:0] s_wstrb,
    input  logic                        s_wvalid,
    output logic                        s_wready,
    output logic [1:0]                  s_bresp,
    output logic                        s_bvalid,
    input  logic                        s_bready,
    input  logic [`AXI_ADDR_BITS-1:0]   s_araddr,
    input  logic                        s_arvalid,
    output logic                        s_arready,
    output logic [`AXI_DATA_BITS-1:0]   s_rdata,
    output logic [1:0]                  s_rresp,
    output logic                        s_rvalid,
    input  logic                        s_rready
);

    logic       in_fire;
    logic       dec_valid;
    raw_value_t dec_value;

    accum_result_if res_if ();

    assign in_fire = in_valid && in_ready;

    posit_decoder u_decoder (
        .clk       (clk),
        .rst       (rst),
        .in_posit  (in_posit),
        .in_fire   (in_fire),
        .dec_valid (dec_valid),
        .dec_value (dec_value)
    );

    raw_accumulator u_accum (
        .clk           (clk),
        .rst           (rst),
        .dec_valid     (dec_valid),
        .dec_value     (dec_value),
        .busy_in_ready (in_ready),
        .res           (res_if.acc)
    );

    accum_axil_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .s_awaddr  (s_awaddr),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .s_wdata   (s_wdata),
        .s_wstrb   (s_wstrb),
        .s_wvalid  (s_wvalid),
        .s_wready  (s_wready),
        .s_bresp   (s_bresp),
        .s_bvalid  (s_bvalid),
        .s_bready  (s_bready),
        .s_araddr  (s_araddr),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .s_rdata   (s_rdata),
        .s_rresp   (s_rresp),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready),
        .res       (res_if.regs)
    );

endmodule

// File: hdl/accum_axil_regs.sv
/* AXI4-Lite slave for the accumulator result, status and clear.
   One outstanding transaction per channel, responses are always OKAY */
`include "posit_accum_params.svh"

module accum_axil_regs
    import accum_regs_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`AXI_ADDR_BITS-1:0]   s_awaddr,
    input  logic                        s_awvalid,
    output logic                        s_awready,
    input  logic [`AXI_DATA_BITS-1:0]   s_wdata,
    input  logic [`AXI_DATA_BITS/8-1:0] s_wstrb,
    input  logic                        s_wvalid,
    output logic                        s_wready,
    output logic [1:0]                  s_bresp,
    output logic                        s_bvalid,
    input  logic                        s_bready,
    input  logic [`AXI_ADDR_BITS-1:0]   s_araddr,
    input  logic                        s_arvalid,
    output logic                        s_arready,
    output logic [`AXI_DATA_BITS-1:0]   s_rdata,
    output logic [1:0]                  s_rresp,
    output logic                        s_rvalid,
    input  logic                        s_rready,
    accum_result_if.regs                res
);

    logic                      wr_fire;
    logic                      rd_fire;
    logic                      clear_q;
    reg_addr_e                 wr_addr;
    reg_addr_e                 rd_addr;
    logic [`AXI_DATA_BITS-1:0] rd_word;

    // Address and data are taken together
    assign wr_fire   = s_awvalid && s_wvalid && !s_bvalid;
    assign s_awready = wr_fire;
    assign s_wready  = wr_fire;
    assign s_bresp   = 2'b00;
    assign wr_addr   = reg_addr_e'(s_awaddr);

    assign s_arready = !s_rvalid;
    assign rd_fire   = s_arvalid && s_arready;
    assign s_rresp   = 2'b00;
    assign rd_addr   = reg_addr_e'(s_araddr);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            s_bvalid <= 1'b0;
            clear_q  <= 1'b0;
        end
        else
        begin
            clear_q <= wr_fire && wr_addr == REG_CTRL && s_wstrb[0] &&
                       s_wdata[CTRL_CLEAR_BIT];
            if (wr_fire)
                s_bvalid <= 1'b1;
            else if (s_bready)
                s_bvalid <= 1'b0;
        end
    end

    assign res.clear = clear_q;

    always_comb
    begin
        rd_word = '0;
        case (rd_addr)
            REG_STATUS:
            begin
                rd_word[STATUS_BUSY_BIT]        = res.busy;
                rd_word[STATUS_TRUNC_BIT]       = res.truncated;
                rd_word[STATUS_INF_BIT]         = res.sum.inf;
                rd_word[STATUS_COUNT_LSB +: 16] = res.count;
            end
            REG_FRAC:
                rd_word[`FBITS_ACCUM-1:0] = res.sum.fraction;
            REG_EXP:
            begin
                rd_word[`SCALE_BITS-1:0] = res.sum.scale;
                rd_word[EXP_SGN_BIT]     = res.sum.sgn;
                rd_word[EXP_ZERO_BIT]    = res.sum.zero;
            end
            // REG_CTRL and holes read as zero
            default:
                rd_word = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            s_rvalid <= 1'b0;
        else if (rd_fire)
            s_rvalid <= 1'b1;
        else if (s_rready)
            s_rvalid <= 1'b0;
    end

    // Data is captured once per read and held until rready
    always_ff @(posedge clk)
    begin
        if (rd_fire)
            s_rdata <= rd_word;
    end

    a_resp_hold: assert property (@(posedge clk) disable iff (rst)
        (s_bvalid && !s_bready |=> s_bvalid) and
        (s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata)));

endmodule

// File: hdl/raw_accumulator.sv
/* Align, add and normalize into a raw feedback sum, one item in flight.
   Results truncate, there is no rounding. Scale beyond +-255 or an inf
   operand latches inf until clear */
`include "posit_accum_params.svh"

module raw_accumulator
    import posit_types_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         dec_valid,
    input  raw_value_t   dec_value,
    output logic         busy_in_ready,
    accum_result_if.acc  res
);

    localparam int MAG_W     = `FBITS_ACCUM + 1;
    // Beyond this the low operand is all lost bits
    localparam int MAX_SHIFT = MAG_W + 2;
    localparam int SCALE_MAX = 2 ** (`SCALE_BITS - 1) - 1;

    raw_value_t  acc_q;
    logic        trunc_q;
    logic [15:0] count_q;
    logic        busy;

    // Operand capture
    logic       v_in;
    raw_value_t op_q;

    // Align stage
    logic                          new_is_hi;
    raw_value_t                    hi_c;
    raw_value_t                    lo_c;
    logic signed [`SCALE_BITS:0]   diff_c;
    logic [5:0]                    shamt_c;
    logic [MAG_W+MAX_SHIFT-1:0]    wide_c;
    logic                          v_align;
    addsub_op_e                    op_a;
    raw_value_t                    hi_a;
    logic [MAG_W-1:0]              hi_mag_a;
    logic [MAG_W-1:0]              lo_mag_a;
    logic                          lost_a;
    logic                          inf_a;

    // Add stage
    logic                          v_add;
    logic [MAG_W:0]                sum_raw;
    logic                          sgn_s;
    logic signed [`SCALE_BITS-1:0] scale_s;
    logic                          lost_s;
    logic                          inf_s;

    // Normalize stage
    logic [4:0]                    lz;
    logic                          found;
    logic [MAG_W-1:0]              shifted_n;
    logic signed [`SCALE_BITS+1:0] scale_n;
    logic                          lost_n;
    raw_value_t                    norm_c;

    assign busy          = dec_valid || v_in || v_align || v_add;
    assign busy_in_ready = !busy;

    always_comb
    begin
        // Tie goes to the new operand
        new_is_hi = acc_q.zero || (!op_q.zero &&
                    ($signed(op_q.scale) > $signed(acc_q.scale) ||
                     (op_q.scale == acc_q.scale && op_q.fraction >= acc_q.fraction)));
        hi_c = new_is_hi ? op_q : acc_q;
        lo_c = new_is_hi ? acc_q : op_q;

        if (lo_c.zero)
            diff_c = '0;
        else
            diff_c = $signed(hi_c.scale) - $signed(lo_c.scale);

        if (diff_c > MAX_SHIFT)
            shamt_c = 6'(MAX_SHIFT);
        else
            shamt_c = diff_c[5:0];

        wide_c = {~lo_c.zero, lo_c.fraction, {MAX_SHIFT{1'b0}}} >> shamt_c;
    end

    assign hi_mag_a = {~hi_a.zero, hi_a.fraction};

    always_comb
    begin
        lz    = '0;
        found = 1'b0;
        for (int i = MAG_W - 1; i >= 0; i--)
        begin
            if (!found && !sum_raw[i])
                lz = lz + 5'd1;
            else
                found = 1'b1;
        end
        shifted_n = sum_raw[MAG_W-1:0] << lz;

        lost_n = 1'b0;
        norm_c = '0;
        if (sum_raw[MAG_W])
        begin
            // Carry out, the dropped bit is lost
            scale_n = $signed(scale_s) + 1;
            lost_n  = sum_raw[0];
            norm_c.fraction = sum_raw[MAG_W-1:1];
        end
        else
        begin
            scale_n = $signed(scale_s) - $signed({1'b0, lz});
            norm_c.fraction = shifted_n[MAG_W-2:0];
        end

        if (inf_s)
        begin
            norm_c     = '0;
            norm_c.inf = 1'b1;
        end
        else if (sum_raw == '0)
        begin
            norm_c      = '0;
            norm_c.zero = 1'b1;
        end
        else if (scale_n > SCALE_MAX || scale_n < -SCALE_MAX)
        begin
            norm_c     = '0;
            norm_c.inf = 1'b1;
        end
        else
        begin
            norm_c.sgn   = sgn_s;
            norm_c.scale = scale_n[`SCALE_BITS-1:0];
        end
    end

    always_ff @(posedge clk)
    begin
        if (dec_valid)
            op_q <= dec_value;

        op_a     <= (hi_c.sgn != lo_c.sgn) ? OP_SUB : OP_ADD;
        hi_a     <= hi_c;
        lo_mag_a <= wide_c[MAX_SHIFT +: MAG_W];
        lost_a   <= |wide_c[MAX_SHIFT-1:0];
        inf_a    <= op_q.inf || acc_q.inf;

        // hi is never below the aligned low operand
        if (op_a == OP_ADD)
            sum_raw <= hi_mag_a + lo_mag_a;
        else
            sum_raw <= hi_mag_a - lo_mag_a;
        sgn_s   <= hi_a.sgn;
        scale_s <= hi_a.scale;
        lost_s  <= lost_a;
        inf_s   <= inf_a;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            acc_q      <= '0;
            acc_q.zero <= 1'b1;
            trunc_q    <= 1'b0;
            count_q    <= '0;
            v_in       <= 1'b0;
            v_align    <= 1'b0;
            v_add      <= 1'b0;
        end
        else if (res.clear)
        begin
            // Also drops anything in flight
            acc_q      <= '0;
            acc_q.zero <= 1'b1;
            trunc_q    <= 1'b0;
            count_q    <= '0;
            v_in       <= 1'b0;
            v_align    <= 1'b0;
            v_add      <= 1'b0;
        end
        else
        begin
            v_in    <= dec_valid;
            v_align <= v_in;
            v_add   <= v_align;
            if (v_add)
            begin
                acc_q   <= norm_c;
                trunc_q <= trunc_q || lost_s || lost_n;
                count_q <= count_q + 16'd1;
            end
        end
    end

    assign res.sum       = acc_q;
    assign res.truncated = trunc_q;
    assign res.busy      = busy;
    assign res.count     = count_q;

    // The sum is read by align, so a new item must wait for writeback
    a_one_in_flight: assert property (@(posedge clk) disable iff (rst)
        dec_valid |-> !(v_in || v_align || v_add));

    a_diff_positive: assert property (@(posedge clk) disable iff (rst)
        v_in |-> diff_c >= 0);

endmodule

// File: hdl/posit_decoder.sv
/* Registered 16-bit es3 posit decoder, one cycle from in_fire to dec_valid.
   dec_value holds until the next accepted word */
`include "posit_accum_params.svh"

module posit_decoder
    import posit_types_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`POSIT_WIDTH-1:0] in_posit,
    input  logic                    in_fire,
    output logic                    dec_valid,
    output raw_value_t              dec_value
);

    localparam int BODY_W = `POSIT_WIDTH - 1;
    localparam int K_W    = `SCALE_BITS - `POSIT_ES;
    localparam int TAIL_W = BODY_W - `POSIT_ES;

    logic [`POSIT_WIDTH-1:0] mag;
    logic [BODY_W-1:0]       rest;
    logic [4:0]              run_len;
    logic                    run_end;
    logic signed [K_W-1:0]   k;
    raw_value_t              value_c;

    always_comb
    begin
        mag = in_posit[`POSIT_WIDTH-1] ? (~in_posit + 1'b1) : in_posit;

        // Regime run length
        run_len = '0;
        run_end = 1'b0;
        for (int i = BODY_W - 1; i >= 0; i--)
        begin
            if (!run_end && mag[i] == mag[BODY_W-1])
                run_len = run_len + 5'd1;
            else
                run_end = 1'b1;
        end

        // Drop the run and its terminator, exponent then fraction remain
        rest = mag[BODY_W-1:0] << (run_len + 5'd1);

        if (mag[BODY_W-1])
            k = $signed({1'b0, run_len}) - 6'sd1;
        else
            k = -$signed({1'b0, run_len});

        value_c = '0;
        if (in_posit == '0)
            value_c.zero = 1'b1;
        else if (in_posit == {1'b1, {BODY_W{1'b0}}})
            value_c.inf = 1'b1;
        else
        begin
            value_c.sgn      = in_posit[`POSIT_WIDTH-1];
            // 8k + e, the exponent fills the low bits
            value_c.scale    = {k, rest[BODY_W-1 -: `POSIT_ES]};
            value_c.fraction = {rest[TAIL_W-1:0], {(`FBITS_ACCUM - TAIL_W){1'b0}}};
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            dec_valid <= 1'b0;
        else
            dec_valid <= in_fire;
    end

    always_ff @(posedge clk)
    begin
        if (in_fire)
            dec_value <= value_c;
    end

    // The input gate admits one word per accumulator pass
    a_single_valid: assert property (@(posedge clk) disable iff (rst)
        dec_valid |=> !dec_valid);

endmodule

// File: hdl/accum_result_if.sv
/* Sum, flags and clear between the accumulator and the register block.
   count wraps at 16 bits, clear is a single-cycle pulse */
interface accum_result_if;

    posit_types_pkg::raw_value_t sum;
    logic                        truncated;
    logic                        busy;
    logic [15:0]                 count;
    logic                        clear;

    modport acc (
        output sum, truncated, busy, count,
        input  clear
    );

    modport regs (
        input  sum, truncated, busy, count,
        output clear
    );

endinterface

// File: hdl/accum_regs_pkg.sv
/* AXI4-Lite register map of the accumulator.
   Unmapped addresses read as 0 */
`include "posit_accum_params.svh"

package accum_regs_pkg;

    typedef enum logic [`AXI_ADDR_BITS-1:0] {
        REG_CTRL   = 4'h0,
        REG_STATUS = 4'h4,
        REG_FRAC   = 4'h8,
        REG_EXP    = 4'hC
    } reg_addr_e;

    // REG_CTRL, write only
    localparam int CTRL_CLEAR_BIT = 0;

    // REG_STATUS
    localparam int STATUS_BUSY_BIT  = 0;
    localparam int STATUS_TRUNC_BIT = 1;
    localparam int STATUS_INF_BIT   = 2;
    localparam int STATUS_COUNT_LSB = 16;

    // REG_EXP, scale sits in the low bits
    localparam int EXP_SGN_BIT  = 16;
    localparam int EXP_ZERO_BIT = 17;

endpackage

// File: hdl/posit_types_pkg.sv
/* Raw value form shared by the decoder and the accumulator.
   Value is (-1)^sgn * 2^scale * 1.fraction, zero and inf override it */
`include "posit_accum_params.svh"

package posit_types_pkg;

    // All other fields are 0 when zero or inf is set
    typedef struct packed {
        logic                          sgn;
        logic signed [`SCALE_BITS-1:0] scale;
        logic [`FBITS_ACCUM-1:0]       fraction;
        logic                          inf;
        logic                          zero;
    } raw_value_t;

    // Subtract when the operand signs differ
    typedef enum logic {
        OP_ADD,
        OP_SUB
    } addsub_op_e;

endpackage

// File: hdl/posit_accum_params.svh
/* Format and bus widths for the posit accumulator.
   Only es = 3 and 16-bit posits are supported by the decoder */
`ifndef POSIT_ACCUM_PARAMS_SVH
`define POSIT_ACCUM_PARAMS_SVH

// Input posit format
`define POSIT_WIDTH 16
`define POSIT_ES 3

// Accumulator fraction without the hidden bit
`define FBITS_ACCUM 24

// Signed scale, covers +-255 before inf
`define SCALE_BITS 9

// AXI4-Lite register port
`define AXI_ADDR_BITS 4
`define AXI_DATA_BITS 32

`endif
